//--- ex_data_pkg.sv
// Data widths and vector types shared by the execute stage RTL and its testbench
`default_nettype none

package ex_data_pkg;

  // Word and register file geometry fixed by the ISA
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Operand and result word
  typedef logic [XLEN-1:0] word_t;

  // Full product of two words
  typedef logic [2*XLEN-1:0] dword_t;

  // Destination register index
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage : ex_data_pkg

`default_nettype wire

//--- ex_op_pkg.sv
// Operation and unit-select encodings of the instruction set seen by the execute stage
`default_nettype none

package ex_op_pkg;

  // ALU and branch compare operations
  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA,
    SLT, SLTU,
    BEQ, BNE, BLT, BGE
  } alu_op_e;

  // Multiply flavours, low word or high word
  typedef enum logic [1:0] {
    MUL, MULH, MULHU
  } mult_op_e;

  // Target unit of an instruction
  typedef enum logic [1:0] {
    UNIT_ALU, UNIT_MULT, UNIT_BRANCH
  } ex_unit_e;

endpackage : ex_op_pkg

`default_nettype wire

//--- ex_mult_if.sv
// Start/done link between the issue control and the iterative multiplier
`timescale 1ns/1ps
`default_nettype none

interface ex_mult_if import ex_data_pkg::*, ex_op_pkg::*; ();

  // Request side
  logic     start;
  mult_op_e op;
  word_t    op_a;
  word_t    op_b;

  // Status and result side
  logic     busy;
  logic     done;
  word_t    result;

  modport issue (output start, op, op_a, op_b, input busy, done, result);
  modport mult  (input start, op, op_a, op_b, output busy, done, result);

endinterface : ex_mult_if

`default_nettype wire

//--- ex_result_if.sv
// Valid/ready result channel from the issue control into the EX/WB register
`timescale 1ns/1ps
`default_nettype none

interface ex_result_if import ex_data_pkg::*; ();

  // Transfer when valid and ready are both high
  logic      valid;
  logic      ready;

  // Payload, held stable while valid waits for ready
  logic      we;
  reg_addr_t waddr;
  word_t     wdata;

  modport issue (output valid, we, waddr, wdata, input ready);
  modport wb    (input valid, we, waddr, wdata, output ready);

endinterface : ex_result_if

`default_nettype wire

//--- ex_alu.sv
// Combinational ALU and branch comparator, instantiated once in the execute stage top
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_data_pkg::*, ex_op_pkg::*; (
  input  alu_op_e alu_op_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    cmp_result_o
);

  // Shared compare terms
  logic             lt_signed;
  logic             lt_unsigned;
  logic             equal;
  logic [4:0]       shamt;

  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;
  assign equal       = operand_a_i == operand_b_i;

  // Only the low five bits of b count as shift amount
  assign shamt = operand_b_i[4:0];

  //////////////////////////////
  // Comparison bit
  //////////////////////////////

  // One bit serves SLT, SLTU and all branch compares
  always_comb begin
    unique case (alu_op_i)
      SLT, BLT: cmp_result_o = lt_signed;
      SLTU:     cmp_result_o = lt_unsigned;
      BEQ:      cmp_result_o = equal;
      BNE:      cmp_result_o = ~equal;
      BGE:      cmp_result_o = ~lt_signed;
      default:  cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // Result word
  //////////////////////////////

  always_comb begin
    unique case (alu_op_i)
      ADD:       result_o = operand_a_i + operand_b_i;
      SUB:       result_o = operand_a_i - operand_b_i;
      AND:       result_o = operand_a_i & operand_b_i;
      OR:        result_o = operand_a_i | operand_b_i;
      XOR:       result_o = operand_a_i ^ operand_b_i;
      SLL:       result_o = operand_a_i << shamt;
      SRL:       result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      SRA:       result_o = word_t'($signed(operand_a_i) >>> shamt);
      // Set-less-than returns the compare bit zero-extended
      SLT, SLTU: result_o = word_t'(cmp_result_o);
      // Branch compares do not write a register
      default:   result_o = '0;
    endcase
  end

endmodule : ex_alu

`default_nettype wire

//--- ex_mult.sv
// Iterative shift-add multiplier with early exit, driven by the issue control over ex_mult_if
`timescale 1ns/1ps
`default_nettype none

module ex_mult import ex_data_pkg::*, ex_op_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  ex_mult_if.mult      mult_if
);

  typedef enum logic [1:0] {IDLE, RUN, FIX} mult_state_e;

  mult_state_e state_q;
  mult_state_e state_d;

  // Operation context captured at start
  mult_op_e    op_q;
  logic        neg_q;

  // Shifting multiplicand, remaining multiplier bits, running sum
  dword_t      mcand_q;
  word_t       mplier_q;
  dword_t      acc_q;

  // Magnitudes only for signed high word
  logic        signed_op;
  word_t       mag_a;
  word_t       mag_b;
  dword_t      product;

  assign signed_op = mult_if.op == MULH;
  assign mag_a     = (signed_op && mult_if.op_a[XLEN-1]) ? -mult_if.op_a : mult_if.op_a;
  assign mag_b     = (signed_op && mult_if.op_b[XLEN-1]) ? -mult_if.op_b : mult_if.op_b;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (mult_if.start) state_d = RUN;
      // Leave as soon as no multiplier bits are left
      RUN:     if (mplier_q == '0) state_d = FIX;
      // Back to back start is legal here since busy is low
      FIX:     state_d = mult_if.start ? RUN : IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (mult_if.start) begin
      op_q     <= mult_if.op;
      neg_q    <= signed_op & (mult_if.op_a[XLEN-1] ^ mult_if.op_b[XLEN-1]);
      mcand_q  <= dword_t'(mag_a);
      mplier_q <= mag_b;
      acc_q    <= '0;
    end else if (state_q == RUN && mplier_q != '0) begin
      // One multiplier bit per cycle
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // Sign fix applied on the way out in FIX
  assign product = neg_q ? -acc_q : acc_q;

  assign mult_if.busy   = state_q == RUN;
  assign mult_if.done   = state_q == FIX;
  assign mult_if.result = (op_q == MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

  // Issue side must wait for busy to drop before the next start
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    mult_if.start |-> !mult_if.busy);

endmodule : ex_mult

`default_nettype wire

//--- ex_issue.sv
// Issue control of the execute stage: steers instructions, picks results and drives forwarding
`timescale 1ns/1ps
`default_nettype none

module ex_issue import ex_data_pkg::*, ex_op_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  ex_unit_e  unit_sel_i,
  input  alu_op_e   alu_op_i,
  input  mult_op_e  mult_op_i,
  input  word_t     operand_a_i,
  input  word_t     operand_b_i,
  input  reg_addr_t waddr_i,
  input  logic      we_i,
  input  word_t     alu_result_i,
  input  logic      alu_cmp_i,
  output logic      branch_decision_o,
  output logic      fw_we_o,
  output reg_addr_t fw_waddr_o,
  output word_t     fw_wdata_o,
  ex_mult_if.issue  mult_if,
  ex_result_if.issue res_if
);

  logic      is_alu;
  logic      is_mult;
  logic      is_branch;
  logic      blocked;
  logic      accept;

  // Multiply result waiting for the EX/WB register
  logic      pend_q;
  word_t     pend_wdata_q;
  logic      mult_res_valid;
  word_t     mult_res_data;

  // Destination of the multiply in flight
  logic      dst_we_q;
  reg_addr_t dst_waddr_q;

  assign is_alu    = unit_sel_i == UNIT_ALU;
  assign is_mult   = unit_sel_i == UNIT_MULT;
  assign is_branch = unit_sel_i == UNIT_BRANCH;

  assign mult_res_valid = mult_if.done | pend_q;
  assign mult_res_data  = pend_q ? pend_wdata_q : mult_if.result;

  // A running or finished multiply owns the result channel
  assign blocked = mult_if.busy | mult_res_valid;

  //////////////////////////////
  // Input handshake
  //////////////////////////////

  // Branches bypass the WB register, so back-pressure does not stall them
  assign in_ready_o = is_branch | (~blocked & res_if.ready);
  assign accept     = in_valid_i & in_ready_o;

  assign branch_decision_o = in_valid_i & is_branch & alu_cmp_i;

  // Multiplier request straight from the inputs
  assign mult_if.start = accept & is_mult;
  assign mult_if.op    = mult_op_i;
  assign mult_if.op_a  = operand_a_i;
  assign mult_if.op_b  = operand_b_i;

  // Destination latched at start, result kept from the done cycle
  always_ff @(posedge clk) begin
    if (mult_if.start) begin
      dst_we_q    <= we_i;
      dst_waddr_q <= waddr_i;
    end
    if (mult_if.done) begin
      pend_wdata_q <= mult_if.result;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (mult_if.done && !res_if.ready) begin
      pend_q <= 1'b1;
    end else if (pend_q && res_if.ready) begin
      pend_q <= 1'b0;
    end
  end

  //////////////////////////////
  // Result channel
  //////////////////////////////

  // Multiply result first, otherwise the ALU instruction at the inputs
  assign res_if.valid = mult_res_valid | (in_valid_i & is_alu & ~blocked);
  assign res_if.we    = mult_res_valid ? dst_we_q    : we_i;
  assign res_if.waddr = mult_res_valid ? dst_waddr_q : waddr_i;
  assign res_if.wdata = mult_res_valid ? mult_res_data : alu_result_i;

  // Forward whatever is handed on this cycle
  assign fw_we_o    = res_if.valid & res_if.ready & res_if.we;
  assign fw_waddr_o = res_if.waddr;
  assign fw_wdata_o = res_if.wdata;

  // Upstream must hold the instruction and the multiplier path must hold its result
  a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
    res_if.valid && !res_if.ready |=>
      res_if.valid && $stable(res_if.we) && $stable(res_if.waddr) && $stable(res_if.wdata));

  // Branch compares come only with the branch unit, other ALU ops only with the ALU
  a_op_unit: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid_i && !is_mult |-> is_branch == (alu_op_i inside {BEQ, BNE, BLT, BGE}));

endmodule : ex_issue

`default_nettype wire

//--- ex_wb_reg.sv
// One-entry EX/WB pipeline register between the issue control and the write-back stage
`timescale 1ns/1ps
`default_nettype none

module ex_wb_reg import ex_data_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  ex_result_if.wb   res_if,
  output logic      wb_valid_o,
  input  logic      wb_ready_i,
  output logic      wb_we_o,
  output reg_addr_t wb_waddr_o,
  output word_t     wb_wdata_o
);

  // Take a new entry when empty or when the current one drains now
  assign res_if.ready = ~wb_valid_o | wb_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o <= 1'b0;
    end else if (res_if.valid && res_if.ready) begin
      wb_valid_o <= 1'b1;
    end else if (wb_ready_i) begin
      wb_valid_o <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (res_if.valid && res_if.ready) begin
      wb_we_o    <= res_if.we;
      wb_waddr_o <= res_if.waddr;
      wb_wdata_o <= res_if.wdata;
    end
  end

  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_o && !wb_ready_i |=>
      wb_valid_o && $stable(wb_we_o) && $stable(wb_waddr_o) && $stable(wb_wdata_o));

endmodule : ex_wb_reg

`default_nettype wire

//--- ex_stage.sv
// Top level of the integer execute stage, connects ALU, multiplier, issue control and EX/WB register
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_data_pkg::*, ex_op_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Instruction input
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  ex_unit_e  unit_sel_i,
  input  alu_op_e   alu_op_i,
  input  mult_op_e  mult_op_i,
  input  word_t     operand_a_i,
  input  word_t     operand_b_i,
  input  word_t     operand_c_i,
  input  reg_addr_t waddr_i,
  input  logic      we_i,
  // Branch outcome toward fetch
  output logic      branch_decision_o,
  output word_t     jump_target_o,
  // Forwarding toward decode
  output logic      fw_we_o,
  output reg_addr_t fw_waddr_o,
  output word_t     fw_wdata_o,
  // Write-back side
  output logic      wb_valid_o,
  input  logic      wb_ready_i,
  output logic      wb_we_o,
  output reg_addr_t wb_waddr_o,
  output word_t     wb_wdata_o,
  output logic      mult_busy_o
);

  word_t alu_result;
  logic  alu_cmp;

  ex_mult_if   mult_if ();
  ex_result_if res_if ();

  // Target passes straight through from operand c
  assign jump_target_o = operand_c_i;
  assign mult_busy_o   = mult_if.busy;

  ex_alu i_alu (
    .alu_op_i     (alu_op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  ex_mult i_mult (
    .clk     (clk),
    .rst_n   (rst_n),
    .mult_if (mult_if.mult)
  );

  ex_issue i_issue (
    .clk               (clk),
    .rst_n             (rst_n),
    .in_valid_i        (in_valid_i),
    .in_ready_o        (in_ready_o),
    .unit_sel_i        (unit_sel_i),
    .alu_op_i          (alu_op_i),
    .mult_op_i         (mult_op_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .waddr_i           (waddr_i),
    .we_i              (we_i),
    .alu_result_i      (alu_result),
    .alu_cmp_i         (alu_cmp),
    .branch_decision_o (branch_decision_o),
    .fw_we_o           (fw_we_o),
    .fw_waddr_o        (fw_waddr_o),
    .fw_wdata_o        (fw_wdata_o),
    .mult_if           (mult_if.issue),
    .res_if            (res_if.issue)
  );

  ex_wb_reg i_wb_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .res_if     (res_if.wb),
    .wb_valid_o (wb_valid_o),
    .wb_ready_i (wb_ready_i),
    .wb_we_o    (wb_we_o),
    .wb_waddr_o (wb_waddr_o),
    .wb_wdata_o (wb_wdata_o)
  );

endmodule : ex_stage

`default_nettype wire

//--- tb_clk_gen.sv
// Clock and reset source for the execute stage testbench, instantiated once by its top module
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running clock with a 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset low for four rising edges, released away from the active edge
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule : tb_clk_gen

`default_nettype wire

//--- tb_ex_stage.sv
// Table-driven testbench of the execute stage, simulation top that drives ex_stage as i_dut
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage import ex_data_pkg::*, ex_op_pkg::*; ();

  // One instruction with its expected outcome
  typedef struct {
    ex_unit_e  unit;
    alu_op_e   aop;
    mult_op_e  mop;
    word_t     a;
    word_t     b;
    word_t     c;
    reg_addr_t rd;
    logic      we;
    word_t     exp_word;
    logic      exp_dec;
  } entry_t;

  // Destination and data seen on the forwarding port
  typedef struct {
    reg_addr_t rd;
    word_t     data;
  } fw_rec_t;

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  logic      in_ready;
  ex_unit_e  unit_sel;
  alu_op_e   alu_op;
  mult_op_e  mult_op;
  word_t     op_a;
  word_t     op_b;
  word_t     op_c;
  reg_addr_t waddr;
  logic      we;
  logic      branch_dec;
  word_t     jump_target;
  logic      fw_we;
  reg_addr_t fw_waddr;
  word_t     fw_wdata;
  logic      wb_valid;
  logic      wb_ready;
  logic      wb_we;
  reg_addr_t wb_waddr;
  word_t     wb_wdata;
  logic      mult_busy;

  // Stimulus table, accepted results in issue order, forwarding log
  entry_t      table_q[$];
  entry_t      exp_q[$];
  fw_rec_t     fw_q[$];
  bit          ready_pat[$];
  int          seed = 32'hde0bc23a;
  int unsigned cycle_limit;
  int unsigned cycle_cnt = 0;
  int unsigned wb_idx = 0;
  int unsigned fw_idx = 0;

  // Snapshot of the WB outputs while stalled
  logic        hold_armed = 1'b0;
  logic        held_we;
  reg_addr_t   held_rd;
  word_t       held_data;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .in_valid_i        (in_valid),
    .in_ready_o        (in_ready),
    .unit_sel_i        (unit_sel),
    .alu_op_i          (alu_op),
    .mult_op_i         (mult_op),
    .operand_a_i       (op_a),
    .operand_b_i       (op_b),
    .operand_c_i       (op_c),
    .waddr_i           (waddr),
    .we_i              (we),
    .branch_decision_o (branch_dec),
    .jump_target_o     (jump_target),
    .fw_we_o           (fw_we),
    .fw_waddr_o        (fw_waddr),
    .fw_wdata_o        (fw_wdata),
    .wb_valid_o        (wb_valid),
    .wb_ready_i        (wb_ready),
    .wb_we_o           (wb_we),
    .wb_waddr_o        (wb_waddr),
    .wb_wdata_o        (wb_wdata),
    .mult_busy_o       (mult_busy)
  );

  //////////////////////////////
  // Failure reporting and checks
  //////////////////////////////

  task automatic stop_with_fail(string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  task automatic check_word(string what, word_t got, word_t exp);
    if (got !== exp) begin
      stop_with_fail($sformatf("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_addr(string what, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) begin
      stop_with_fail($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    if (got !== exp) begin
      stop_with_fail($sformatf("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
    logic [4:0] sh;
    word_t      r;
    sh = b[4:0];
    case (op)
      ADD:     r = a + b;
      SUB:     r = a + ~b + 32'd1;
      AND:     r = a & b;
      OR:      r = a | b;
      XOR:     r = a ^ b;
      SLL:     r = a << sh;
      SRL:     r = a >> sh;
      // Logical shift, then fill the vacated top bits with the sign
      SRA:     r = (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
      // Flipping the sign bit turns a signed order into an unsigned one
      SLT:     r = word_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
      SLTU:    r = word_t'(a < b);
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic ref_cmp(alu_op_e op, word_t a, word_t b);
    logic lt;
    logic r;
    lt = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (op)
      BEQ:     r = a == b;
      BNE:     r = a != b;
      BLT:     r = lt;
      BGE:     r = !lt;
      default: r = 1'b0;
    endcase
    return r;
  endfunction

  // Full 64-bit products, signed and unsigned
  function automatic word_t ref_mult(mult_op_e op, word_t a, word_t b);
    dword_t sp;
    dword_t up;
    word_t  r;
    sp = dword_t'(longint'($signed(a)) * longint'($signed(b)));
    up = dword_t'(a) * dword_t'(b);
    case (op)
      MUL:     r = up[XLEN-1:0];
      MULH:    r = sp[2*XLEN-1:XLEN];
      default: r = up[2*XLEN-1:XLEN];
    endcase
    return r;
  endfunction

  //////////////////////////////
  // Table construction
  //////////////////////////////

  task automatic add_alu(alu_op_e op, word_t a, word_t b, reg_addr_t rd, logic w, word_t exp);
    entry_t e;
    e = '{UNIT_ALU, op, MUL, a, b, 32'h0, rd, w, exp, 1'b0};
    table_q.push_back(e);
  endtask

  // Expected word of a branch is its jump target
  task automatic add_branch(alu_op_e op, word_t a, word_t b, word_t c, logic dec);
    entry_t e;
    e = '{UNIT_BRANCH, op, MUL, a, b, c, 5'd0, 1'b0, c, dec};
    table_q.push_back(e);
  endtask

  task automatic add_mult(mult_op_e op, word_t a, word_t b, reg_addr_t rd, word_t exp);
    entry_t e;
    e = '{UNIT_MULT, ADD, op, a, b, 32'h0, rd, 1'b1, exp, 1'b0};
    table_q.push_back(e);
  endtask

  task automatic build_table();
    int       i;
    word_t    ra;
    word_t    rb;
    word_t    rc;
    word_t    bb;
    alu_op_e  aop;
    alu_op_e  bop;
    mult_op_e mop;
    // Directed ALU values, signed edges for SLT and SLTU
    add_alu(ADD,  32'h0000_0005, 32'h0000_0007, 5'd1,  1'b1, 32'h0000_000c);
    add_alu(ADD,  32'hffff_ffff, 32'h0000_0001, 5'd2,  1'b1, 32'h0000_0000);
    add_alu(SUB,  32'h0000_0003, 32'h0000_0005, 5'd3,  1'b1, 32'hffff_fffe);
    add_alu(AND,  32'hf0f0_f0f0, 32'hff00_ff00, 5'd4,  1'b1, 32'hf000_f000);
    add_alu(OR,   32'hf0f0_f0f0, 32'h0f00_000f, 5'd5,  1'b1, 32'hfff0_f0ff);
    add_alu(XOR,  32'haaaa_5555, 32'hffff_0000, 5'd6,  1'b1, 32'h5555_5555);
    // Shift amount 0x23 uses only its low five bits
    add_alu(SLL,  32'h0000_0001, 32'h0000_0023, 5'd7,  1'b1, 32'h0000_0008);
    add_alu(SRL,  32'h8000_0000, 32'h0000_001f, 5'd8,  1'b1, 32'h0000_0001);
    add_alu(SRA,  32'h8000_0000, 32'h0000_0004, 5'd9,  1'b1, 32'hf800_0000);
    add_alu(SLT,  32'h8000_0000, 32'h7fff_ffff, 5'd10, 1'b1, 32'h0000_0001);
    add_alu(SLTU, 32'h8000_0000, 32'h7fff_ffff, 5'd11, 1'b1, 32'h0000_0000);
    add_alu(SLT,  32'hffff_ffff, 32'h0000_0000, 5'd12, 1'b1, 32'h0000_0001);
    add_alu(SLTU, 32'h0000_0000, 32'hffff_ffff, 5'd13, 1'b1, 32'h0000_0001);
    // No register write, so nothing is forwarded
    add_alu(ADD,  32'h0000_0001, 32'h0000_0001, 5'd14, 1'b0, 32'h0000_0002);
    // Directed branches
    add_branch(BEQ, 32'h0000_0005, 32'h0000_0005, 32'h0000_1000, 1'b1);
    add_branch(BNE, 32'h0000_0005, 32'h0000_0005, 32'h0000_2004, 1'b0);
    add_branch(BLT, 32'hffff_ffff, 32'h0000_0001, 32'h0000_3008, 1'b1);
    add_branch(BLT, 32'h0000_0001, 32'hffff_ffff, 32'h0000_300c, 1'b0);
    add_branch(BGE, 32'h8000_0000, 32'h0000_0000, 32'h0000_4010, 1'b0);
    add_branch(BGE, 32'h0000_0007, 32'h0000_0007, 32'h0000_4014, 1'b1);
    // Directed multiplies, zero and one operands and negative pairs
    add_mult(MUL,   32'h0000_0000, 32'h1234_5678, 5'd15, 32'h0000_0000);
    add_mult(MUL,   32'h0000_0001, 32'hdead_beef, 5'd16, 32'hdead_beef);
    add_mult(MULH,  32'hffff_ffff, 32'hffff_ffff, 5'd17, 32'h0000_0000);
    add_mult(MULHU, 32'hffff_ffff, 32'hffff_ffff, 5'd18, 32'hffff_fffe);
    add_mult(MULH,  32'h8000_0000, 32'h8000_0000, 5'd19, 32'h4000_0000);
    add_mult(MULH,  32'hffff_fffe, 32'h0000_0003, 5'd20, 32'hffff_ffff);
    add_mult(MUL,   32'hffff_fffe, 32'h0000_0003, 5'd21, 32'hffff_fffa);
    add_mult(MULHU, 32'h8000_0000, 32'h0000_0002, 5'd22, 32'h0000_0001);
    add_mult(MULH,  32'h7fff_ffff, 32'h8000_0000, 5'd23, 32'hc000_0000);
    // Random mix, each multiply directly followed by ALU and branch work
    for (i = 0; i < 8; i++) begin
      ra  = $random(seed);
      rb  = $random(seed);
      rc  = $random(seed);
      mop = mult_op_e'(i % 3);
      add_mult(mop, ra, rb, reg_addr_t'(24 + i), ref_mult(mop, ra, rb));
      aop = alu_op_e'($unsigned($random(seed)) % 10);
      add_alu(aop, rb, ra, reg_addr_t'(i), 1'b1, ref_alu(aop, rb, ra));
      bop = alu_op_e'(10 + i % 4);
      bb  = (i % 2 == 0) ? ra : rb;
      add_branch(bop, ra, bb, rc, ref_cmp(bop, ra, bb));
    end
  endtask

  // Stall pattern for the WB port, mostly ready with low stretches up to six cycles
  task automatic build_ready_pattern();
    int          r;
    bit          level;
    int unsigned len;
    while (ready_pat.size() < cycle_limit) begin
      r     = $random(seed);
      level = r[1:0] != 2'b00;
      len   = 1 + ($unsigned($random(seed)) % 6);
      repeat (len) ready_pat.push_back(level);
    end
  endtask

  task automatic apply_entry(entry_t e);
    in_valid = 1'b1;
    unit_sel = e.unit;
    alu_op   = e.aop;
    mult_op  = e.mop;
    op_a     = e.a;
    op_b     = e.b;
    op_c     = e.c;
    waddr    = e.rd;
    we       = e.we;
  endtask

  //////////////////////////////
  // Instruction driver
  //////////////////////////////

  initial begin
    in_valid = 1'b0;
    unit_sel = UNIT_ALU;
    alu_op   = ADD;
    mult_op  = MUL;
    op_a     = '0;
    op_b     = '0;
    op_c     = '0;
    waddr    = '0;
    we       = 1'b0;
    build_table();
    cycle_limit = 40 * table_q.size() + 100;
    build_ready_pattern();
    @(posedge rst_n);
    // Idle state right after reset
    @(posedge clk);
    check_bit("wb_valid_o after reset", wb_valid, 1'b0);
    check_bit("fw_we_o after reset", fw_we, 1'b0);
    check_bit("mult_busy_o after reset", mult_busy, 1'b0);
    check_bit("in_ready_o after reset", in_ready, 1'b1);
    foreach (table_q[i]) begin
      @(negedge clk);
      apply_entry(table_q[i]);
      // Hold the entry until the handshake completes on a rising edge
      @(posedge clk);
      while (!in_ready) @(posedge clk);
      if (table_q[i].unit == UNIT_BRANCH) begin
        check_bit($sformatf("branch_decision_o of entry %0d", i), branch_dec, table_q[i].exp_dec);
        check_word($sformatf("jump_target_o of entry %0d", i), jump_target, table_q[i].exp_word);
      end else begin
        exp_q.push_back(table_q[i]);
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    // Drain, then idle a little longer to catch duplicates
    while (wb_idx < exp_q.size()) @(posedge clk);
    repeat (10) @(posedge clk);
    if (wb_idx == exp_q.size() && fw_idx == fw_q.size()) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_with_fail("Forwarding port showed results that never reached the WB port");
    end
  end

  // Write-back side ready, changed on falling edges after reset only
  initial begin
    int unsigned idx;
    idx      = 0;
    wb_ready = 1'b0;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      wb_ready = (idx < ready_pat.size()) ? ready_pat[idx] : 1'b1;
      idx++;
    end
  end

  //////////////////////////////
  // Output monitor and timeout
  //////////////////////////////

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      stop_with_fail($sformatf("Timeout: run not finished after %0d cycles", cycle_limit));
    end
    if (rst_n) begin
      // Forwarding happens when the EX/WB register takes a result
      if (fw_we) begin
        fw_q.push_back(fw_rec_t'{fw_waddr, fw_wdata});
      end
      // Stalled outputs must not move
      if (hold_armed) begin
        check_bit("wb_valid_o under back-pressure", wb_valid, 1'b1);
        check_bit("wb_we_o under back-pressure", wb_we, held_we);
        check_addr("wb_waddr_o under back-pressure", wb_waddr, held_rd);
        check_word("wb_wdata_o under back-pressure", wb_wdata, held_data);
      end
      hold_armed = wb_valid && !wb_ready;
      held_we    = wb_we;
      held_rd    = wb_waddr;
      held_data  = wb_wdata;
      // Each taken WB entry must be the next one in issue order
      if (wb_valid && wb_ready) begin
        if (wb_idx >= exp_q.size()) begin
          stop_with_fail("WB port delivered a result that was never issued");
        end else begin
          check_addr($sformatf("wb_waddr_o of result %0d", wb_idx), wb_waddr, exp_q[wb_idx].rd);
          check_bit($sformatf("wb_we_o of result %0d", wb_idx), wb_we, exp_q[wb_idx].we);
          check_word($sformatf("wb_wdata_o of result %0d", wb_idx), wb_wdata,
                     exp_q[wb_idx].exp_word);
          if (wb_we) begin
            if (fw_idx >= fw_q.size()) begin
              stop_with_fail("A written result reached WB without being forwarded");
            end else begin
              check_addr("fw_waddr_o against WB", fw_q[fw_idx].rd, wb_waddr);
              check_word("fw_wdata_o against WB", fw_q[fw_idx].data, wb_wdata);
              fw_idx++;
            end
          end
          wb_idx++;
        end
      end
    end
  end

endmodule : tb_ex_stage

`default_nettype wire

//--- all.f
ex_data_pkg.sv
ex_op_pkg.sv
ex_mult_if.sv
ex_result_if.sv
ex_alu.sv
ex_mult.sv
ex_issue.sv
ex_wb_reg.sv
ex_stage.sv
tb_clk_gen.sv
tb_ex_stage.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "=== FAIL ===" $(LOG); then echo "Test failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF "=== PASS ===" $(LOG); then echo "No pass report in $(LOG)"; exit 1; fi
	@echo "Test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
